//--- files.f
hdl/cpu_pkg.sv
hdl/insn_ram.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/exec_unit.sv
hdl/cpu_top.sv
test/cpu_props.sv
test/cpu_tb.sv

//--- hdl/alu.sv
`default_nettype none

module alu import cpu_pkg::*; (
    input  word_t insn,
    input  word_t rs_val,
    input  word_t rt_val,
    input  addr_t pc,
    output word_t alu_result,
    output addr_t mem_addr,
    output logic  branch_taken,
    output addr_t branch_target
);

    opcode_t op;
    word_t   imm;
    word_t   eff_addr;
    addr_t   seq_pc;
    addr_t   rel_target;

    assign op  = insn_opcode(insn);
    assign imm = insn_imm_sext(insn);

    // loads and stores share the rs plus offset address
    assign eff_addr = rs_val + imm;
    assign mem_addr = eff_addr[ADDR_W-1:0];

    assign seq_pc     = pc + addr_t'(1);
    assign rel_target = seq_pc + imm[ADDR_W-1:0];

    always_comb begin
        case (op)
            ADD:     alu_result = rs_val + rt_val;
            SUB:     alu_result = rs_val - rt_val;
            AND:     alu_result = rs_val & rt_val;
            OR:      alu_result = rs_val | rt_val;
            XOR:     alu_result = rs_val ^ rt_val;
            ADDI:    alu_result = rs_val + imm;
            LUI:     alu_result = {insn[15:0], 16'h0000};
            default: alu_result = '0;
        endcase
    end

    // branch decision, the target is only used when taken
    always_comb begin
        branch_taken  = 1'b0;
        branch_target = seq_pc;
        case (op)
            BEQZ: begin
                branch_taken  = (rs_val == '0);
                branch_target = rel_target;
            end
            JUMP: begin
                branch_taken  = 1'b1;
                branch_target = insn_target(insn);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int WORD_W     = 32;
    localparam int ADDR_W     = 24;
    localparam int REG_AW     = 4;
    localparam int NUM_REGS   = 1 << REG_AW;
    localparam int IMEM_DEPTH = 1024;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [REG_AW-1:0]  reg_idx_t;
    typedef logic [IMEM_AW-1:0] imem_idx_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction word layout
    //   [31:28] opcode   [27:24] rd   [23:20] rs   [19:16] rt
    //   [15:0]  signed immediate
    //   [23:0]  jump target, overlapping rs, rt and the immediate
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes 12 to 15 are unassigned and execute as no-ops
    typedef enum logic [3:0] {
        HALT  = 4'd0,
        ADD   = 4'd1,
        SUB   = 4'd2,
        AND   = 4'd3,
        OR    = 4'd4,
        XOR   = 4'd5,
        ADDI  = 4'd6,
        LUI   = 4'd7,
        LOAD  = 4'd8,
        STORE = 4'd9,
        BEQZ  = 4'd10,
        JUMP  = 4'd11
    } opcode_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALTED
    } exec_state_t;

    function automatic opcode_t insn_opcode(input word_t insn);
        return opcode_t'(insn[31:28]);
    endfunction

    function automatic reg_idx_t insn_rd(input word_t insn);
        return insn[27:24];
    endfunction

    function automatic reg_idx_t insn_rs(input word_t insn);
        return insn[23:20];
    endfunction

    function automatic reg_idx_t insn_rt(input word_t insn);
        return insn[19:16];
    endfunction

    function automatic word_t insn_imm_sext(input word_t insn);
        return {{(WORD_W - 16){insn[15]}}, insn[15:0]};
    endfunction

    function automatic addr_t insn_target(input word_t insn);
        return insn[ADDR_W-1:0];
    endfunction

endpackage

`default_nettype wire

//--- hdl/cpu_top.sv
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      run,
    input  logic      prog_we,
    input  imem_idx_t prog_addr,
    input  word_t     prog_data,
    output logic      dbus_en,
    output logic      dbus_rw,
    output addr_t     dbus_addr,
    output word_t     dbus_wdata,
    input  word_t     dbus_rdata,
    output addr_t     pc,
    output logic      halted
);

    imem_idx_t imem_addr;
    word_t     imem_rdata;
    word_t     insn;
    word_t     rs_val;
    word_t     rt_val;
    word_t     alu_result;
    addr_t     mem_addr;
    logic      branch_taken;
    addr_t     branch_target;
    logic      rf_we;
    reg_idx_t  rf_waddr;
    word_t     rf_wdata;

    // operand indices come straight off the fetched word during DECODE
    wire reg_idx_t rs_idx = insn_rs(imem_rdata);
    wire reg_idx_t rt_idx = insn_rt(imem_rdata);

    insn_ram u_insn_ram (
        .clk        (clk),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rs_idx   (rs_idx),
        .rt_idx   (rt_idx),
        .rs_val   (rs_val),
        .rt_val   (rt_val),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata)
    );

    alu u_alu (
        .insn          (insn),
        .rs_val        (rs_val),
        .rt_val        (rt_val),
        .pc            (pc),
        .alu_result    (alu_result),
        .mem_addr      (mem_addr),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    exec_unit u_exec_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .run           (run),
        .imem_addr     (imem_addr),
        .imem_rdata    (imem_rdata),
        .insn          (insn),
        .alu_result    (alu_result),
        .mem_addr      (mem_addr),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc),
        .rf_we         (rf_we),
        .rf_waddr      (rf_waddr),
        .rf_wdata      (rf_wdata),
        .dbus_en       (dbus_en),
        .dbus_rw       (dbus_rw),
        .dbus_addr     (dbus_addr),
        .dbus_wdata    (dbus_wdata),
        .dbus_rdata    (dbus_rdata),
        .rt_val        (rt_val),
        .halted        (halted)
    );

endmodule

`default_nettype wire

//--- hdl/exec_unit.sv
`default_nettype none

module exec_unit import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      run,
    output imem_idx_t imem_addr,
    input  word_t     imem_rdata,
    output word_t     insn,
    input  word_t     alu_result,
    input  addr_t     mem_addr,
    input  logic      branch_taken,
    input  addr_t     branch_target,
    output addr_t     pc,
    output logic      rf_we,
    output reg_idx_t  rf_waddr,
    output word_t     rf_wdata,
    output logic      dbus_en,
    output logic      dbus_rw,
    output addr_t     dbus_addr,
    output word_t     dbus_wdata,
    input  word_t     dbus_rdata,
    input  word_t     rt_val,
    output logic      halted
);

    exec_state_t state;
    exec_state_t state_nxt;
    opcode_t     op;
    logic        op_alu;
    logic        op_mem;
    logic        insn_done;
    addr_t       pc_nxt;

    assign op = insn_opcode(insn);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcode classes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        op_alu = 1'b0;
        op_mem = 1'b0;
        case (op)
            ADD, SUB, AND, OR, XOR, ADDI, LUI: op_alu = 1'b1;
            LOAD, STORE:                       op_mem = 1'b1;
            default: ;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (run) begin
                    state_nxt = FETCH;
                end
            end
            FETCH: begin
                state_nxt = DECODE;
            end
            DECODE: begin
                state_nxt = EXECUTE;
            end
            EXECUTE: begin
                if (op == HALT) begin
                    state_nxt = HALTED;
                end else if (op_mem) begin
                    state_nxt = MEMORY;
                end else if (op_alu) begin
                    state_nxt = WRITEBACK;
                end else begin
                    // branches, jumps and undefined opcodes end here
                    state_nxt = FETCH;
                end
            end
            MEMORY: begin
                if (op == LOAD) begin
                    state_nxt = WRITEBACK;
                end else begin
                    state_nxt = FETCH;
                end
            end
            WRITEBACK: begin
                state_nxt = FETCH;
            end
            HALTED: begin
                state_nxt = HALTED;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // an instruction retires whenever the sequencer returns to FETCH
    assign insn_done = (state != IDLE) && (state_nxt == FETCH);

    // the alu only reports taken for BEQZ and JUMP
    assign pc_nxt = branch_taken ? branch_target : pc + addr_t'(1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            pc    <= '0;
        end else begin
            state <= state_nxt;
            if (insn_done) begin
                pc <= pc_nxt;
            end
        end
    end

    // imem_rdata holds the fetched word during DECODE
    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            insn <= imem_rdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch, write-back and data bus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign imem_addr = pc[IMEM_AW-1:0];

    assign rf_we    = (state == WRITEBACK);
    assign rf_waddr = insn_rd(insn);

    // load data arrives the cycle after the MEMORY request, which is WRITEBACK
    assign rf_wdata = (op == LOAD) ? dbus_rdata : alu_result;

    assign dbus_en    = (state == MEMORY);
    assign dbus_rw    = (op == STORE);
    assign dbus_addr  = mem_addr;
    assign dbus_wdata = rt_val;

    assign halted = (state == HALTED);

endmodule

`default_nettype wire

//--- hdl/insn_ram.sv
`default_nettype none

module insn_ram import cpu_pkg::*; (
    input  logic      clk,
    input  logic      prog_we,
    input  imem_idx_t prog_addr,
    input  word_t     prog_data,
    input  imem_idx_t imem_addr,
    output word_t     imem_rdata
);

    word_t mem [0:IMEM_DEPTH-1];

    // load port, only used by the host while the core is not running
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // registered read, the word appears one cycle after the address
    always_ff @(posedge clk) begin
        imem_rdata <= mem[imem_addr];
    end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rs_val,
    output word_t    rt_val,
    input  logic     rf_we,
    input  reg_idx_t rf_waddr,
    input  word_t    rf_wdata
);

    word_t regs [0:NUM_REGS-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register 0 is never stored, the read side supplies its zero
    always_ff @(posedge clk) begin
        if (rf_we && rf_waddr != '0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write-back and decode fall in different cycles of the sequencer,
    // so a read never races a write to the same register
    always_ff @(posedge clk) begin
        if (rs_idx == '0) begin
            rs_val <= '0;
        end else begin
            rs_val <= regs[rs_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rt_idx == '0) begin
            rt_val <= '0;
        end else begin
            rt_val <= regs[rt_idx];
        end
    end

endmodule

`default_nettype wire

//--- test/cpu_props.sv
`default_nettype none

module cpu_props (
    input logic clk,
    input logic rst_n,
    input logic dbus_en,
    input logic rf_we,
    input logic halted
);

    int unsigned assert_fails = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    property quiet_after_reset;
        @(posedge clk) !rst_n |=> (!dbus_en && !rf_we);
    endproperty

    // the bus has no wait states, so a request never holds
    property dbus_single_cycle;
        @(posedge clk) disable iff (!rst_n) dbus_en |=> !dbus_en;
    endproperty

    property halted_sticky;
        @(posedge clk) disable iff (!rst_n) halted |=> halted;
    endproperty

    property no_bus_during_writeback;
        @(posedge clk) disable iff (!rst_n) !(rf_we && dbus_en);
    endproperty

    a_quiet_after_reset: assert property (quiet_after_reset) else begin
        assert_fails++;
        $error("dbus_en or rf_we high in the cycle after reset");
    end

    a_dbus_single_cycle: assert property (dbus_single_cycle) else begin
        assert_fails++;
        $error("dbus_en held for more than one cycle");
    end

    a_halted_sticky: assert property (halted_sticky) else begin
        assert_fails++;
        $error("halted dropped without a reset");
    end

    a_no_bus_during_writeback: assert property (no_bus_during_writeback) else begin
        assert_fails++;
        $error("rf_we and dbus_en high in the same cycle");
    end

endmodule

bind exec_unit cpu_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .dbus_en (dbus_en),
    .rf_we   (rf_we),
    .halted  (halted)
);

`default_nettype wire

//--- test/cpu_tb.sv
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int HALF_PERIOD = 10;
    // instruction cycles of the five tests with the loop test at its largest count
    localparam int RUN_CYCLES = 59 + 11 + 29 + 107 + 30;
    // twice the run time plus room for reset and program loading
    localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES + 300;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      run;
    logic      prog_we;
    imem_idx_t prog_addr;
    word_t     prog_data;
    logic      dbus_en;
    logic      dbus_rw;
    addr_t     dbus_addr;
    word_t     dbus_wdata;
    word_t     dbus_rdata;
    addr_t     pc;
    logic      halted;

    word_t dmem [addr_t];
    addr_t st_addr [$];
    word_t st_data [$];
    logic  rd_pend;
    addr_t rd_addr;
    word_t prog [$];
    string cur_test;
    int    test_errs;
    int    pass_cnt;
    int    fail_cnt;

    cpu_top dut (.*);

    always #HALF_PERIOD clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data memory model with read data one cycle after the request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (rd_pend) begin
            dbus_rdata = dmem.exists(rd_addr) ? dmem[rd_addr] : '0;
        end
        rd_pend = dbus_en && !dbus_rw;
        rd_addr = dbus_addr;
        if (dbus_en && dbus_rw) begin
            dmem[dbus_addr] = dbus_wdata;
            st_addr.push_back(dbus_addr);
            st_data.push_back(dbus_wdata);
        end
    end

    function automatic word_t sext16(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // cycles from entering FETCH until the next FETCH or HALTED
    function automatic int cycles_of(input word_t w);
        case (w[31:28])
            ADD, SUB, AND, OR, XOR, ADDI, LUI, STORE: return 4;
            LOAD:    return 5;
            default: return 3;
        endcase
    endfunction

    task automatic emit(input logic [3:0] op, input reg_idx_t rd, input reg_idx_t rs,
                        input reg_idx_t rt, input logic [15:0] imm);
        prog.push_back({op, rd, rs, rt, imm});
    endtask

    task automatic check_val(input string what, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        assert (cond === 1'b1) else begin
            $display("%s: %s", cur_test, what);
            test_errs++;
        end
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: ok", cur_test);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", cur_test, test_errs);
        end
        test_errs = 0;
    endtask

    // resets the core, loads prog while run is low, then runs until halted
    task automatic run_program(output int cycles);
        int i;
        @(negedge clk);
        rst_n = 1'b0;
        run   = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        for (i = 0; i < prog.size(); i++) begin
            prog_we   = 1'b1;
            prog_addr = imem_idx_t'(i);
            prog_data = prog[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        st_addr.delete();
        st_data.delete();
        run    = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!halted) begin
            cycles++;
            @(negedge clk);
        end
        run = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_alu_ops();
        word_t   ra;
        word_t   rb;
        word_t   va;
        word_t   vb;
        word_t   exp [5];
        opcode_t ops [5];
        int      i;
        int      cycles;
        cur_test = "alu_ops";
        ra = $urandom;
        rb = $urandom;
        // ADDI after LUI sign extends the low half on top of the upper half
        va  = {ra[31:16], 16'h0000} + sext16(ra[15:0]);
        vb  = {rb[31:16], 16'h0000} + sext16(rb[15:0]);
        exp = '{va + vb, va - vb, va & vb, va | vb, va ^ vb};
        ops = '{ADD, SUB, AND, OR, XOR};
        prog.delete();
        emit(LUI, 4'd1, 4'd0, 4'd0, ra[31:16]);
        emit(ADDI, 4'd1, 4'd1, 4'd0, ra[15:0]);
        emit(LUI, 4'd2, 4'd0, 4'd0, rb[31:16]);
        emit(ADDI, 4'd2, 4'd2, 4'd0, rb[15:0]);
        for (i = 0; i < 5; i++) begin
            emit(ops[i], 4'd3, 4'd1, 4'd2, 16'h0000);
            emit(STORE, 4'd0, 4'd0, 4'd3, 16'(256 + i));
        end
        emit(HALT, 4'd0, 4'd0, 4'd0, 16'h0000);
        run_program(cycles);
        check_val("store count", 32'd5, word_t'(st_addr.size()));
        for (i = 0; i < 5 && i < st_addr.size(); i++) begin
            check_val("store address", 32'(256 + i), word_t'(st_addr[i]));
            check_val("store data", exp[i], st_data[i]);
        end
        end_test();
    endtask

    task automatic test_reg_zero();
        int cycles;
        cur_test = "reg_zero";
        prog.delete();
        emit(ADDI, 4'd0, 4'd0, 4'd0, 16'h0055);
        emit(STORE, 4'd0, 4'd0, 4'd0, 16'h0200);
        emit(HALT, 4'd0, 4'd0, 4'd0, 16'h0000);
        run_program(cycles);
        check_val("store count", 32'd1, word_t'(st_addr.size()));
        if (st_addr.size() > 0) begin
            check_val("store address", 32'h200, word_t'(st_addr[0]));
            check_val("register 0 value", 32'h0, st_data[0]);
        end
        end_test();
    endtask

    task automatic test_load_store();
        word_t x;
        word_t y;
        word_t ea;
        int    cycles;
        cur_test = "load_store";
        x = $urandom;
        y = $urandom;
        dmem[24'h000300] = x;
        dmem[24'h000301] = y;
        ea = 32'h310 + sext16(16'hfffc);
        prog.delete();
        emit(ADDI, 4'd5, 4'd0, 4'd0, 16'h0300);
        emit(LOAD, 4'd6, 4'd5, 4'd0, 16'h0000);
        emit(LOAD, 4'd7, 4'd5, 4'd0, 16'h0001);
        emit(ADD, 4'd8, 4'd6, 4'd7, 16'h0000);
        emit(ADDI, 4'd9, 4'd0, 4'd0, 16'h0310);
        emit(STORE, 4'd0, 4'd9, 4'd8, 16'hfffc);
        emit(HALT, 4'd0, 4'd0, 4'd0, 16'h0000);
        run_program(cycles);
        check_val("store count", 32'd1, word_t'(st_addr.size()));
        if (st_addr.size() > 0) begin
            check_val("store address", {8'h00, ea[23:0]}, word_t'(st_addr[0]));
            check_val("store data", x + y, st_data[0]);
        end
        end_test();
    endtask

    task automatic test_branch_loop();
        int n;
        int i;
        int cycles;
        cur_test = "branch_loop";
        n = 1 + ($urandom % 5);
        prog.delete();
        emit(ADDI, 4'd1, 4'd0, 4'd0, 16'(n));
        emit(ADDI, 4'd2, 4'd0, 4'd0, 16'h0400);
        // leave the loop at address 7 once the counter reaches zero
        emit(BEQZ, 4'd0, 4'd1, 4'd0, 16'd4);
        emit(STORE, 4'd0, 4'd2, 4'd1, 16'h0000);
        emit(ADDI, 4'd2, 4'd2, 4'd0, 16'h0001);
        emit(ADDI, 4'd1, 4'd1, 4'd0, 16'hffff);
        // r0 is always zero and so this always goes back to address 2
        emit(BEQZ, 4'd0, 4'd0, 4'd0, 16'hfffb);
        prog.push_back({JUMP, 4'h0, 24'd9});
        emit(STORE, 4'd0, 4'd0, 4'd1, 16'h04ff);
        emit(HALT, 4'd0, 4'd0, 4'd0, 16'h0000);
        run_program(cycles);
        check_val("loop store count", word_t'(n), word_t'(st_addr.size()));
        for (i = 0; i < n && i < st_addr.size(); i++) begin
            check_val("store address", 32'h400 + word_t'(i), word_t'(st_addr[i]));
            check_val("store data", word_t'(n - i), st_data[i]);
        end
        foreach (st_addr[i]) begin
            check_true("a store reached the address skipped by JUMP", st_addr[i] != 24'h4ff);
        end
        end_test();
    endtask

    task automatic test_halt_timing();
        int    i;
        int    exp_cycles;
        int    cycles;
        addr_t halt_pc;
        cur_test = "halt_timing";
        prog.delete();
        emit(ADDI, 4'd1, 4'd0, 4'd0, 16'h0005);
        emit(LUI, 4'd2, 4'd0, 4'd0, 16'h1234);
        emit(ADD, 4'd3, 4'd1, 4'd2, 16'h0000);
        emit(STORE, 4'd0, 4'd0, 4'd3, 16'h0500);
        emit(LOAD, 4'd4, 4'd0, 4'd0, 16'h0500);
        prog.push_back({JUMP, 4'h0, 24'd6});
        // opcode 12 is unassigned
        prog.push_back({4'hc, 28'h0});
        emit(HALT, 4'd0, 4'd0, 4'd0, 16'h0000);
        exp_cycles = 0;
        foreach (prog[i]) begin
            exp_cycles += cycles_of(prog[i]);
        end
        // execution stops with pc on the HALT word at the end of the program
        halt_pc = addr_t'(prog.size() - 1);
        run_program(cycles);
        check_val("cycles from run to halted", word_t'(exp_cycles), word_t'(cycles));
        check_val("store count", 32'd1, word_t'(st_addr.size()));
        if (st_data.size() > 0) begin
            check_val("store data", 32'd5 + {16'h1234, 16'h0000}, st_data[0]);
        end
        check_val("pc at halt", word_t'(halt_pc), word_t'(pc));
        for (i = 0; i < 6; i++) begin
            @(negedge clk);
            check_val("pc after halt", word_t'(halt_pc), word_t'(pc));
            check_true("dbus_en went high after halt", !dbus_en);
        end
        end_test();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        void'($urandom(32'hb1a1_230f));
        rst_n      = 1'b0;
        run        = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        dbus_rdata = '0;
        rd_pend    = 1'b0;
        rd_addr    = '0;
        test_errs  = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        test_alu_ops();
        test_reg_zero();
        test_load_store();
        test_branch_loop();
        test_halt_timing();
        $display("tests passed %0d, tests failed %0d, property failures %0d",
                 pass_cnt, fail_cnt, dut.u_exec_unit.u_props.assert_fails);
        if (fail_cnt == 0 && dut.u_exec_unit.u_props.assert_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the core never reached halt in time",
                 WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
